// ==== dsi_tx_pkg.sv ====
package dsi_tx_pkg;

    // line geometry
    localparam int LINE_PIXELS     = 8;
    localparam int BYTES_PER_PIXEL = 3;
    localparam int LINE_BYTES      = LINE_PIXELS * BYTES_PER_PIXEL; // long packet word count
    localparam int LINE_WORDS      = LINE_BYTES / 4;

    // frame regions in lines
    localparam int VSA_LINES = 1;
    localparam int VBP_LINES = 1;
    localparam int ACT_LINES = 2;
    localparam int VFP_LINES = 1;

    localparam int BLANK_CYCLES = 6; // wait after each sync packet
    localparam int HBP_CYCLES   = 3; // hss to pixel header

    localparam logic [5:0] DT_VSS          = 6'h01;
    localparam logic [5:0] DT_HSS          = 6'h21;
    localparam logic [5:0] DT_PPS24        = 6'h3E;
    localparam logic [1:0] VIRTUAL_CHANNEL = 2'd0;

    localparam logic [15:0] CRC_POLY = 16'h1021; // used bit reversed
    localparam logic [15:0] CRC_SEED = 16'hFFFF;

    typedef struct packed {
        logic [1:0] vc;
        logic [5:0] dt;
    } data_id_t;

    typedef struct packed {
        logic [7:0]  ecc;
        logic [15:0] word_count;
        data_id_t    data_id;
    } pkt_header_t;

    // one queue word, payload or header
    typedef union packed {
        logic [31:0] raw;
        pkt_header_t header;
    } pkt_word_u;

    typedef enum logic [1:0] {
        VSS,
        HSS,
        PIXEL_LINE
    } pkt_kind_e;

    typedef struct packed {
        logic      valid;
        pkt_kind_e kind;
    } pkt_req_t;

    typedef struct packed {
        logic      half; // low two bytes only
        pkt_word_u word;
    } queue_word_t;

endpackage

// ==== dsi_ecc.sv ====
`timescale 1ns/1ps

module dsi_ecc
(
    input  logic [23:0] header,
    output logic [7:0]  ecc
);

    logic [23:0] d;

    assign d = header;

    assign ecc[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
                  ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    assign ecc[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
                  ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
    assign ecc[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
                  ^ d[18] ^ d[20] ^ d[21] ^ d[22];
    assign ecc[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
                  ^ d[19] ^ d[20] ^ d[21] ^ d[23];
    assign ecc[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
                  ^ d[19] ^ d[20] ^ d[22] ^ d[23];
    assign ecc[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
                  ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
    assign ecc[7:6] = 2'b00; // unused in dsi

endmodule

// ==== dsi_crc16.sv ====
`timescale 1ns/1ps

module dsi_crc16
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        write,
    input  logic [31:0] data,
    output logic [15:0] crc
);

    // bytes low first, each byte lsb first
    function automatic logic [15:0] crc_fold(input logic [15:0] crc_in, input logic [31:0] word);
        logic [15:0] poly;
        logic [15:0] poly_r;
        logic [15:0] c;
        poly = dsi_tx_pkg::CRC_POLY;
        for (int i = 0; i < 16; i++)
        begin
            poly_r[i] = poly[15 - i];
        end
        c = crc_in;
        for (int i = 0; i < 32; i++)
        begin
            if (c[0] ^ word[i])
                c = (c >> 1) ^ poly_r;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            crc <= dsi_tx_pkg::CRC_SEED;
        else if (clear)
            crc <= dsi_tx_pkg::CRC_SEED;
        else if (write)
            crc <= crc_fold(crc, data);
    end

endmodule

// ==== dsi_frame_timing.sv ====
`timescale 1ns/1ps

module dsi_frame_timing
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic                 fifo_line_ready,
    output dsi_tx_pkg::pkt_req_t pkt_req,
    input  logic                 pkt_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_VSS,
        ST_BLANK_VSS,
        ST_SEND_HSS,
        ST_HBP,
        ST_SEND_PIX,
        ST_BLANK_LINE
    } state_e;

    typedef enum logic [1:0] {
        REG_VSA,
        REG_VBP,
        REG_ACT,
        REG_VFP
    } region_e;

    state_e      state;
    region_e     region;
    logic [7:0]  wait_cnt;
    logic [7:0]  line_cnt;
    logic        wait_done;
    logic        last_line;

    assign wait_done = (wait_cnt == 8'd0);
    assign last_line = (line_cnt == 8'd1);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            region   <= REG_VSA;
            wait_cnt <= 8'd0;
            line_cnt <= 8'd0;
        end
        else
        begin
            if (!wait_done)
                wait_cnt <= wait_cnt - 8'd1;
            case (state)
                ST_IDLE:
                    if (enable && fifo_line_ready)
                    begin
                        state    <= ST_SEND_VSS;
                        region   <= REG_VSA;
                        line_cnt <= 8'(dsi_tx_pkg::VSA_LINES);
                    end
                ST_SEND_VSS:
                    if (pkt_done)
                    begin
                        state    <= ST_BLANK_VSS;
                        wait_cnt <= 8'(dsi_tx_pkg::BLANK_CYCLES - 1);
                    end
                ST_BLANK_VSS:
                    if (wait_done)
                        state <= ST_SEND_HSS;
                ST_SEND_HSS:
                    if (pkt_done)
                    begin
                        if (region == REG_ACT)
                        begin
                            state    <= ST_HBP;
                            wait_cnt <= 8'(dsi_tx_pkg::HBP_CYCLES - 1);
                        end
                        else
                        begin
                            state    <= ST_BLANK_LINE;
                            wait_cnt <= 8'(dsi_tx_pkg::BLANK_CYCLES - 1);
                        end
                    end
                ST_HBP:
                    if (wait_done)
                        state <= ST_SEND_PIX;
                ST_SEND_PIX:
                    if (pkt_done)
                    begin
                        state    <= ST_BLANK_LINE;
                        wait_cnt <= 8'(dsi_tx_pkg::BLANK_CYCLES - dsi_tx_pkg::HBP_CYCLES - 1);
                    end
                ST_BLANK_LINE:
                    if (wait_done)
                    begin
                        state <= ST_SEND_HSS;
                        if (!last_line)
                            line_cnt <= line_cnt - 8'd1;
                        else
                        begin
                            case (region)
                                REG_VSA:
                                begin
                                    region   <= REG_VBP;
                                    line_cnt <= 8'(dsi_tx_pkg::VBP_LINES);
                                end
                                REG_VBP:
                                begin
                                    region   <= REG_ACT;
                                    line_cnt <= 8'(dsi_tx_pkg::ACT_LINES);
                                end
                                REG_ACT:
                                begin
                                    region   <= REG_VFP;
                                    line_cnt <= 8'(dsi_tx_pkg::VFP_LINES);
                                end
                                default:
                                    state <= ST_IDLE; // frame complete
                            endcase
                        end
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_comb
    begin
        pkt_req.valid = (state == ST_SEND_VSS) || (state == ST_SEND_HSS)
                     || (state == ST_SEND_PIX);
        case (state)
            ST_SEND_HSS: pkt_req.kind = dsi_tx_pkg::HSS;
            ST_SEND_PIX: pkt_req.kind = dsi_tx_pkg::PIXEL_LINE;
            default:     pkt_req.kind = dsi_tx_pkg::VSS;
        endcase
    end

endmodule

// ==== dsi_packet_builder.sv ====
`timescale 1ns/1ps

module dsi_packet_builder
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  dsi_tx_pkg::pkt_req_t    pkt_req,
    output logic                    pkt_done,
    input  logic [31:0]             fifo_data,
    input  logic                    fifo_not_empty,
    input  logic                    fifo_line_ready,
    output logic                    fifo_read_ack,
    output dsi_tx_pkg::queue_word_t queue_head,
    output logic                    queue_empty,
    input  logic                    word_pop,
    output logic                    underflow
);

    typedef enum logic [1:0] {
        B_IDLE,
        B_PAYLOAD,
        B_CRC
    } bstate_e;

    bstate_e                 state;
    logic [7:0]              rem;
    dsi_tx_pkg::queue_word_t mem [4];
    logic [1:0]              wr_ptr;
    logic [1:0]              rd_ptr;
    logic [2:0]              count;
    logic                    queue_full;
    logic                    is_pixel;
    dsi_tx_pkg::data_id_t    data_id;
    logic [15:0]             word_count;
    logic [7:0]              ecc;
    dsi_tx_pkg::pkt_header_t hdr;
    logic                    push;
    dsi_tx_pkg::queue_word_t push_word;
    logic                    crc_clear;
    logic [15:0]             crc;

    assign is_pixel   = (pkt_req.kind == dsi_tx_pkg::PIXEL_LINE);
    assign queue_full = (count == 3'd4);
    assign underflow  = (state == B_IDLE) && pkt_req.valid && is_pixel && !fifo_line_ready;

    always_comb
    begin
        data_id.vc = dsi_tx_pkg::VIRTUAL_CHANNEL;
        case (pkt_req.kind)
            dsi_tx_pkg::HSS:        data_id.dt = dsi_tx_pkg::DT_HSS;
            dsi_tx_pkg::PIXEL_LINE: data_id.dt = dsi_tx_pkg::DT_PPS24;
            default:                data_id.dt = dsi_tx_pkg::DT_VSS;
        endcase
        word_count = is_pixel ? 16'(dsi_tx_pkg::LINE_BYTES) : 16'd0;
        hdr = '{ecc: ecc, word_count: word_count, data_id: data_id};
    end

    dsi_ecc u_ecc
    (
        .header ({word_count, data_id}),
        .ecc    (ecc)
    );

    dsi_crc16 u_crc16
    (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (crc_clear),
        .write (fifo_read_ack),
        .data  (fifo_data),
        .crc   (crc)
    );

    always_comb
    begin
        push          = 1'b0;
        push_word     = '0;
        fifo_read_ack = 1'b0;
        crc_clear     = 1'b0;
        pkt_done      = 1'b0;
        case (state)
            B_IDLE:
                if (pkt_req.valid && !queue_full && (!is_pixel || fifo_line_ready))
                begin
                    push                  = 1'b1;
                    push_word.word.header = hdr;
                    pkt_done              = !is_pixel; // sync packet is one word
                    crc_clear             = is_pixel;
                end
            B_PAYLOAD:
                if (!queue_full && fifo_not_empty)
                begin
                    push               = 1'b1;
                    push_word.word.raw = fifo_data;
                    fifo_read_ack      = 1'b1;
                end
            default:
                if (!queue_full)
                begin
                    push               = 1'b1;
                    push_word.half     = 1'b1;
                    push_word.word.raw = {16'h0000, crc}; // crc footer
                    pkt_done           = 1'b1;
                end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= B_IDLE;
            rem   <= 8'd0;
        end
        else
        begin
            case (state)
                B_IDLE:
                    if (push && is_pixel)
                    begin
                        state <= B_PAYLOAD;
                        rem   <= 8'(dsi_tx_pkg::LINE_WORDS);
                    end
                B_PAYLOAD:
                    if (fifo_read_ack)
                    begin
                        rem <= rem - 8'd1;
                        if (rem == 8'd1)
                            state <= B_CRC;
                    end
                default:
                    if (push)
                        state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 2'd1;
            if (word_pop)
                rd_ptr <= rd_ptr + 2'd1;
            if (push && !word_pop)
                count <= count + 3'd1;
            else if (word_pop && !push)
                count <= count - 3'd1;
        end
    end

    assign queue_head  = mem[rd_ptr];
    assign queue_empty = (count == 3'd0);

endmodule

// ==== dsi_lane_repacker.sv ====
`timescale 1ns/1ps

module dsi_lane_repacker
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [2:0]              lanes_number,
    input  dsi_tx_pkg::queue_word_t queue_head,
    input  logic                    queue_empty,
    output logic                    word_pop,
    output logic [31:0]             phy_data,
    output logic [3:0]              phy_write,
    input  logic [3:0]              phy_full
);

    logic [63:0] shift_reg;
    logic [3:0]  byte_cnt;   // valid bytes in shift_reg
    logic [3:0]  lanes;
    logic [3:0]  in_bytes;
    logic [31:0] in_word;
    logic        emit;
    logic [3:0]  out_bytes;
    logic [3:0]  free_bytes;
    logic [3:0]  keep_bytes;
    logic [63:0] shifted;
    logic [63:0] inserted;

    assign lanes    = {1'b0, lanes_number};
    assign in_bytes = queue_head.half ? 4'd2 : 4'd4;
    assign in_word  = queue_head.half ? {16'h0000, queue_head.word.raw[15:0]}
                                      : queue_head.word.raw;

    // partial group only when nothing more is queued
    assign emit = !(|phy_full) && ((byte_cnt >= lanes) || ((byte_cnt != 4'd0) && queue_empty));
    assign out_bytes  = !emit ? 4'd0 : ((byte_cnt >= lanes) ? lanes : byte_cnt);
    assign free_bytes = 4'd8 - byte_cnt + out_bytes;
    assign word_pop   = !queue_empty && (free_bytes >= 4'd4);
    assign keep_bytes = byte_cnt - out_bytes;

    assign shifted  = shift_reg >> {out_bytes, 3'b000};
    assign inserted = word_pop ? ({32'h0, in_word} << {keep_bytes, 3'b000}) : 64'h0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg <= 64'h0;
            byte_cnt  <= 4'd0;
        end
        else
        begin
            shift_reg <= shifted | inserted;
            byte_cnt  <= keep_bytes + (word_pop ? in_bytes : 4'd0);
        end
    end

    assign phy_data  = shift_reg[31:0]; // byte i to lane i
    assign phy_write = ~(4'hF << out_bytes);

endmodule

// ==== dsi_tx_top.sv ====
`timescale 1ns/1ps

module dsi_tx_top
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        enable,
    input  logic [2:0]  lanes_number,
    input  logic [31:0] fifo_data,
    input  logic        fifo_not_empty,
    input  logic        fifo_line_ready,
    output logic        fifo_read_ack,
    output logic [31:0] phy_data,
    output logic [3:0]  phy_write,
    input  logic [3:0]  phy_full,
    output logic        pix_buffer_underflow_set
);

    dsi_tx_pkg::pkt_req_t    pkt_req;
    logic                    pkt_done;
    dsi_tx_pkg::queue_word_t queue_head;
    logic                    queue_empty;
    logic                    word_pop;

    dsi_frame_timing u_frame_timing
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .enable          (enable),
        .fifo_line_ready (fifo_line_ready),
        .pkt_req         (pkt_req),
        .pkt_done        (pkt_done)
    );

    dsi_packet_builder u_packet_builder
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .pkt_req         (pkt_req),
        .pkt_done        (pkt_done),
        .fifo_data       (fifo_data),
        .fifo_not_empty  (fifo_not_empty),
        .fifo_line_ready (fifo_line_ready),
        .fifo_read_ack   (fifo_read_ack),
        .queue_head      (queue_head),
        .queue_empty     (queue_empty),
        .word_pop        (word_pop),
        .underflow       (pix_buffer_underflow_set)
    );

    dsi_lane_repacker u_lane_repacker
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .lanes_number (lanes_number),
        .queue_head   (queue_head),
        .queue_empty  (queue_empty),
        .word_pop     (word_pop),
        .phy_data     (phy_data),
        .phy_write    (phy_write),
        .phy_full     (phy_full)
    );

endmodule

// ==== dsi_tx_checker.sv ====
`timescale 1ns/1ps

module dsi_tx_checker
(
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] phy_write,
    input logic [3:0] phy_full,
    input logic       fifo_read_ack,
    input logic       fifo_not_empty
);

    a_lanes_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        (phy_write & (phy_write + 4'd1)) == 4'd0)
        else $error("phy_write strobes are not contiguous from lane 0");

    a_no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (phy_full != 4'd0) |-> (phy_write == 4'd0))
        else $error("phy_write raised while phy_full is set");

    a_ack_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_read_ack |-> fifo_not_empty)
        else $error("fifo_read_ack raised with an empty source FIFO");

endmodule

bind dsi_tx_top dsi_tx_checker u_checker
(
    .clk            (clk),
    .rst_n          (rst_n),
    .phy_write      (phy_write),
    .phy_full       (phy_full),
    .fifo_read_ack  (fifo_read_ack),
    .fifo_not_empty (fifo_not_empty)
);

// ==== tb_dsi_tx.sv ====
`timescale 1ns/1ps

module tb_dsi_tx;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [2:0]  lanes_number;
    logic [31:0] fifo_data;
    logic        fifo_not_empty;
    logic        fifo_line_ready;
    logic        fifo_read_ack;
    logic [31:0] phy_data;
    logic [3:0]  phy_write;
    logic [3:0]  phy_full;
    logic        pix_buffer_underflow_set;

    logic [31:0]               lcg_state;
    logic                      stall_en;
    logic                      underflow_seen;
    logic [31:0]               fifo_q[$];    // source FIFO model with fifo_data as head
    logic [31:0]               pix_words[$];
    logic [7:0]                exp_q[$];
    logic [7:0]                rx_q[$];
    int                        hdr_pos[$];
    dsi_tx_pkg::pkt_header_t   hdr_exp[$];

    dsi_tx_top u_dsi_tx_top
    (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .enable                   (enable),
        .lanes_number             (lanes_number),
        .fifo_data                (fifo_data),
        .fifo_not_empty           (fifo_not_empty),
        .fifo_line_ready          (fifo_line_ready),
        .fifo_read_ack            (fifo_read_ack),
        .phy_data                 (phy_data),
        .phy_write                (phy_write),
        .phy_full                 (phy_full),
        .pix_buffer_underflow_set (pix_buffer_underflow_set)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // dsi hamming parity with one mask per ecc bit
    function automatic logic [7:0] ref_ecc(input logic [23:0] h);
        logic [23:0] masks [6];
        logic [7:0]  e;
        masks = '{24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
        e = 8'h00;
        for (int i = 0; i < 6; i++)
            e[i] = ^(h & masks[i]);
        return e;
    endfunction

    function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ b[i])
                c = (c >> 1) ^ 16'h8408; // 1021 reflected
            else
                c = c >> 1;
        end
        return c;
    endfunction

    function automatic dsi_tx_pkg::pkt_header_t make_header(input logic [5:0] dt,
                                                            input logic [15:0] wc);
        dsi_tx_pkg::pkt_header_t h;
        h.data_id.vc = dsi_tx_pkg::VIRTUAL_CHANNEL;
        h.data_id.dt = dt;
        h.word_count = wc;
        h.ecc        = ref_ecc({wc, h.data_id});
        return h;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_bytes(input string name, input int idx,
                                 input logic [7:0] expected, input logic [7:0] actual);
        if (expected !== actual)
            report_failure($sformatf("error %s: byte %0d expected %02h actual %02h",
                                     name, idx, expected, actual));
    endtask

    task automatic compare_header(input string name, input dsi_tx_pkg::pkt_header_t expected,
                                  input dsi_tx_pkg::pkt_header_t actual);
        if (expected !== actual)
            report_failure($sformatf("error %s: header expected %08h actual %08h",
                                     name, expected, actual));
    endtask

    task automatic compare_count(input string name, input int expected, input int actual);
        if (expected != actual)
            report_failure($sformatf("error %s: byte count expected %0d actual %0d",
                                     name, expected, actual));
    endtask

    task automatic drive_fifo();
        fifo_not_empty = (fifo_q.size() != 0);
        fifo_data      = (fifo_q.size() != 0) ? fifo_q[0] : 32'h0;
    endtask

    // sample at the rising edge and drive at the falling edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        if (fifo_read_ack)
        begin
            if (!fifo_not_empty || fifo_q.size() == 0)
                report_failure("fifo_read_ack was raised while the source FIFO was empty");
            fifo_q.delete(0);
        end
        if (phy_write != 4'd0 && phy_full != 4'd0)
            report_failure("a PHY lane was strobed while phy_full was set");
        if ((phy_write & (phy_write + 4'd1)) != 4'd0)
            report_failure("PHY lane strobes were not contiguous from lane 0");
        if ($countones(phy_write) > int'(lanes_number))
            report_failure("more PHY lanes were strobed than lanes_number allows");
        for (int i = 0; i < 4; i++)
        begin
            if (phy_write[i])
                rx_q.push_back(phy_data[8 * i +: 8]);
        end
        if (pix_buffer_underflow_set)
            underflow_seen = 1'b1;
        @(negedge clk);
        r = lcg_next();
        phy_full = (stall_en && r[30]) ? r[27:24] : 4'b0000;
        drive_fifo();
    endtask

    task automatic add_header(input dsi_tx_pkg::pkt_header_t h);
        hdr_pos.push_back(exp_q.size());
        hdr_exp.push_back(h);
        for (int b = 0; b < 4; b++)
            exp_q.push_back(h[8 * b +: 8]);
    endtask

    task automatic make_pixels();
        pix_words.delete();
        for (int i = 0; i < dsi_tx_pkg::ACT_LINES * dsi_tx_pkg::LINE_WORDS; i++)
            pix_words.push_back(lcg_next());
    endtask

    // expected frame stream and the FIFO contents that feed it
    task automatic load_frame();
        logic [15:0] crc;
        logic [31:0] w;
        int          p;
        exp_q.delete();
        hdr_pos.delete();
        hdr_exp.delete();
        fifo_q.delete();
        p = 0;
        add_header(make_header(dsi_tx_pkg::DT_VSS, 16'd0));
        for (int l = 0; l < dsi_tx_pkg::VSA_LINES + dsi_tx_pkg::VBP_LINES; l++)
            add_header(make_header(dsi_tx_pkg::DT_HSS, 16'd0));
        for (int l = 0; l < dsi_tx_pkg::ACT_LINES; l++)
        begin
            add_header(make_header(dsi_tx_pkg::DT_HSS, 16'd0));
            add_header(make_header(dsi_tx_pkg::DT_PPS24, 16'(dsi_tx_pkg::LINE_BYTES)));
            crc = dsi_tx_pkg::CRC_SEED;
            for (int k = 0; k < dsi_tx_pkg::LINE_WORDS; k++)
            begin
                w = pix_words[p];
                p++;
                fifo_q.push_back(w);
                for (int b = 0; b < 4; b++)
                begin
                    exp_q.push_back(w[8 * b +: 8]);
                    crc = crc_byte(crc, w[8 * b +: 8]);
                end
            end
            exp_q.push_back(crc[7:0]);
            exp_q.push_back(crc[15:8]);
        end
        for (int l = 0; l < dsi_tx_pkg::VFP_LINES; l++)
            add_header(make_header(dsi_tx_pkg::DT_HSS, 16'd0));
        drive_fifo();
    endtask

    task automatic wait_first_strobe(input string name);
        int n;
        n = 0;
        while (rx_q.size() == 0)
        begin
            if (n == 200)
                report_failure($sformatf("%s: timed out waiting for the first PHY strobe", name));
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_bytes(input string name, input int count);
        int n;
        n = 0;
        while (rx_q.size() < count)
        begin
            if (n == 3000)
                report_failure($sformatf("%s: timed out waiting for the frame bytes", name));
            next_cycle();
            n++;
        end
    endtask

    // received header bytes against the reference ecc
    task automatic check_headers(input string name);
        dsi_tx_pkg::pkt_header_t act;
        int                      p;
        foreach (hdr_pos[i])
        begin
            p   = hdr_pos[i];
            act = {rx_q[p + 3], rx_q[p + 2], rx_q[p + 1], rx_q[p]};
            compare_header(name, hdr_exp[i], act);
        end
    endtask

    task automatic finish_frame(input string name);
        wait_bytes(name, exp_q.size());
        repeat (40) next_cycle(); // trailing bytes would show up here
        compare_count(name, exp_q.size(), rx_q.size());
        check_headers(name);
        for (int i = 0; i < exp_q.size(); i++)
            compare_bytes(name, i, exp_q[i], rx_q[i]);
        compare_count({name, " fifo words left"}, 0, fifo_q.size());
    endtask

    task automatic run_frame(input string name, input logic [2:0] lanes, input logic stalls);
        load_frame();
        rx_q.delete();
        underflow_seen  = 1'b0;
        lanes_number    = lanes;
        stall_en        = stalls;
        fifo_line_ready = 1'b1;
        enable          = 1'b1;
        wait_first_strobe(name);
        enable = 1'b0; // one frame only
        finish_frame(name);
        stall_en = 1'b0;
    endtask

    task automatic test_four_lanes();
        make_pixels();
        run_frame("four_lanes", 3'd4, 1'b0);
        if (underflow_seen)
            report_failure("four_lanes: underflow was raised although a line was ready");
    endtask

    // same pixel words as the four lane frame
    task automatic test_narrow_lanes();
        for (int lanes = 1; lanes <= 2; lanes++)
        begin
            run_frame($sformatf("lanes_%0d", lanes), 3'(lanes), 1'b0);
        end
    endtask

    task automatic test_random_stalls();
        make_pixels();
        run_frame("random_stalls", 3'd4, 1'b1);
    endtask

    task automatic test_underflow();
        int n;
        int pre_bytes;
        pre_bytes = 4 * (dsi_tx_pkg::VSA_LINES + dsi_tx_pkg::VBP_LINES + 2); // vss and hss
        make_pixels();
        load_frame();
        rx_q.delete();
        underflow_seen  = 1'b0;
        lanes_number    = 3'd4;
        fifo_line_ready = 1'b1;
        enable          = 1'b1;
        wait_first_strobe("underflow");
        enable          = 1'b0;
        fifo_line_ready = 1'b0;
        n = 0;
        while (!underflow_seen)
        begin
            if (n == 500)
                report_failure("underflow: pix_buffer_underflow_set never rose");
            next_cycle();
            n++;
        end
        repeat (20) next_cycle();
        compare_count("underflow_hold", pre_bytes, rx_q.size());
        underflow_seen = 1'b0;
        next_cycle();
        if (!underflow_seen)
            report_failure("underflow: flag dropped while the line was still not ready");
        fifo_line_ready = 1'b1;
        finish_frame("underflow");
    endtask

    task automatic test_enable_gate();
        make_pixels();
        load_frame();
        rx_q.delete();
        enable          = 1'b0;
        lanes_number    = 3'd4;
        fifo_line_ready = 1'b1;
        repeat (60) next_cycle();
        compare_count("enable_low", 0, rx_q.size());
        run_frame("enable_gate", 3'd4, 1'b0);
    endtask

    initial
    begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        enable          = 1'b0;
        lanes_number    = 3'd4;
        fifo_data       = 32'h0;
        fifo_not_empty  = 1'b0;
        fifo_line_ready = 1'b0;
        phy_full        = 4'b0000;
        lcg_state       = 32'hae9;
        stall_en        = 1'b0;
        underflow_seen  = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_four_lanes();
        test_narrow_lanes();
        test_random_stalls();
        test_underflow();
        test_enable_gate();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
dsi_tx_pkg.sv
dsi_ecc.sv
dsi_crc16.sv
dsi_frame_timing.sv
dsi_packet_builder.sv
dsi_lane_repacker.sv
dsi_tx_top.sv
dsi_tx_checker.sv
tb_dsi_tx.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dsi tx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dsi_tx -f verilog.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dsi_tx +verilator+error+limit+10 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1
